//--- sources.f
+incdir+rtl
rtl/fir_pkg.sv
rtl/mac_slice.sv
rtl/sym_fir.sv
rtl/fir_regs.sv
rtl/fir_top.sv
bench/fir_tb.sv

//--- bench/fir_tb.sv
// testbench for fir_top with APB programming, table-driven sample streams and a direct-form model
// every row ends with zero samples, so no output mixes two register settings
// the pulse after sample t carries y[t - LAT + 1]
// history is zero before the run
// idle gaps are capped at 3 cycles per sample, which bounds the run length
// the table is written for FIR_HALF_TAPS = 4
`timescale 1ns/1ps
`include "fir_cfg.svh"

module fir_tb;

   localparam int H        = `FIR_HALF_TAPS;
   localparam int DW       = `FIR_DATA_W;
   localparam int CW       = `FIR_COEF_W;
   localparam int AW       = `APB_ADDR_W;
   localparam int PW       = `APB_DATA_W;
   localparam int LAT      = `FIR_SLICE_LAT + H - 1;   // valid cycles in to out
   localparam int FLUSH    = 2 * H + LAT;              // trailing zeros per row
   localparam int NUM_ROWS = 9;
   localparam int APB_CYC  = 40;                       // 12 transfers of 3 cycles rounded up
   localparam int MARGIN   = 100;
   localparam longint MAX_OUT = (longint'(1) <<< (DW - 1)) - 1;
   localparam longint MIN_OUT = -(longint'(1) <<< (DW - 1));

   localparam logic [1:0] IMPULSE = 2'd0;
   localparam logic [1:0] STEP    = 2'd1;
   localparam logic [1:0] RANDOM  = 2'd2;

   // one test row
   typedef struct packed {
      logic                 prog;     // 0 leaves the reset values in place
      logic [1:0]           mode;     // {neg_out, pre_sub}
      logic [H-1:0][CW-1:0] coef;
      int                   count;    // pattern samples before the zero tail
      int                   gap_pct;  // chance of an idle cycle before a sample
      logic [1:0]           kind;
      logic signed [DW-1:0] amp;      // impulse and step height
   } row_t;

   logic              clock;
   logic              arst_n;
   fir_pkg::apb_req_t apb_req;
   fir_pkg::apb_rsp_t apb_rsp;
   fir_pkg::sample_t  samp_in;
   fir_pkg::sample_t  samp_out;

   row_t                 rows [NUM_ROWS];
   int                   x_hist [$];   // every accepted sample since the run began
   logic signed [DW-1:0] exp_q [$];    // expected out.data per accepted sample
   logic                 valid_at_edge; // in.valid seen by the last rising edge
   logic signed [DW-1:0] held_data;
   int                   value_errors;
   int                   other_errors;
   int                   compared;
   int                   cycles;
   int                   cycle_limit;

   fir_top uut (
      .clock   (clock),
      .arst_n  (arst_n),
      .apb_req (apb_req),
      .apb_rsp (apb_rsp),
      .in      (samp_in),
      .out     (samp_out)
   );

   always #5 clock = ~clock;

   // reference model
   function automatic int hist_at(input int idx);
      if (idx < 0)
         return 0;   // nothing before the first sample
      return x_hist[idx];
   endfunction

   // y[n] = sum coef[k] * (x[n-k] +/- x[n-(2H-1-k)]) then negate, shift and clamp
   function automatic logic signed [DW-1:0] model_out(input int n, input row_t row);
      longint acc;
      longint pair;
      acc = 0;
      for (int k = 0; k < H; k++) begin
         if (row.mode[0])
            pair = hist_at(n - k) - hist_at(n - (2 * H - 1 - k));
         else
            pair = hist_at(n - k) + hist_at(n - (2 * H - 1 - k));
         acc = acc + longint'($signed(row.coef[k])) * pair;
      end
      if (row.mode[1])
         acc = -acc;
      acc = acc >>> `FIR_OUT_SHIFT;   // arithmetic shift floors toward minus infinity
      if (acc > MAX_OUT)
         acc = MAX_OUT;
      else if (acc < MIN_OUT)
         acc = MIN_OUT;
      return DW'(acc);
   endfunction

   task automatic note_sample(input logic signed [DW-1:0] value, input row_t row);
      x_hist.push_back(value);
      exp_q.push_back(model_out(x_hist.size() - LAT, row));   // what the next pulse shows
   endtask

   // one APB transfer through setup and access phases back to idle
   task automatic bus_transfer(input logic write, input logic [AW-1:0] addr,
                               input logic [PW-1:0] wdata, input logic exp_err,
                               output logic [PW-1:0] rdata);
      @(negedge clock);
      apb_req.psel    = 1'b1;
      apb_req.penable = 1'b0;
      apb_req.pwrite  = write;
      apb_req.paddr   = addr;
      apb_req.pwdata  = wdata;
      @(negedge clock);
      apb_req.penable = 1'b1;
      #1;   // response is combinational on the request
      rdata = apb_rsp.prdata;
      if (apb_rsp.pready !== 1'b1) begin
         value_errors++;
         $display("CHECK FAILED at %0t: apb_rsp.pready expected 1 got %b", $time,
                  apb_rsp.pready);
      end
      if (apb_rsp.pslverr !== exp_err) begin
         value_errors++;
         $display("CHECK FAILED at %0t: apb_rsp.pslverr at 0x%02h expected %b got %b",
                  $time, addr, exp_err, apb_rsp.pslverr);
      end
      @(negedge clock);
      apb_req = '0;
   endtask

   task automatic write_reg(input logic [AW-1:0] addr, input logic [PW-1:0] data,
                            input logic exp_err);
      logic [PW-1:0] unused;
      bus_transfer(1'b1, addr, data, exp_err, unused);
   endtask

   task automatic read_check(input logic [AW-1:0] addr, input logic [PW-1:0] exp_data,
                             input logic exp_err);
      logic [PW-1:0] rdata;
      bus_transfer(1'b0, addr, '0, exp_err, rdata);
      if (!exp_err && rdata !== exp_data) begin
         value_errors++;
         $display("CHECK FAILED at %0t: apb_rsp.prdata at 0x%02h expected 0x%08h got 0x%08h",
                  $time, addr, exp_data, rdata);
      end
   endtask

   task automatic program_regs(input row_t row);
      logic [AW-1:0] addr;
      if (row.prog) begin
         write_reg(`FIR_REG_MODE, {{(PW - 2){1'b0}}, row.mode}, 1'b0);
         for (int k = 0; k < H; k++) begin
            addr = AW'(`FIR_REG_COEF0 + 4 * k);
            write_reg(addr, {{(PW - CW){1'b0}}, row.coef[k]}, 1'b0);
         end
         write_reg(AW'(`FIR_REG_COEF0 + 4 * H), 32'hdead_beef, 1'b1);   // past the last coef
      end
      read_check(`FIR_REG_MODE, {{(PW - 2){1'b0}}, row.mode}, 1'b0);
      for (int k = 0; k < H; k++) begin
         addr = AW'(`FIR_REG_COEF0 + 4 * k);
         read_check(addr, PW'(longint'($signed(row.coef[k]))), 1'b0);   // signed value
      end
      read_check(8'h04, '0, 1'b1);   // hole between mode and coef 0
   endtask

   task automatic send_sample(input logic signed [DW-1:0] value, input row_t row);
      int gaps;
      gaps = 0;
      while (gaps < 3 && $urandom_range(99) < row.gap_pct) begin
         @(negedge clock);
         samp_in.valid = 1'b0;
         gaps++;
      end
      @(negedge clock);
      samp_in.valid = 1'b1;
      samp_in.data  = value;
      note_sample(value, row);
   endtask

   task automatic run_row(input int r);
      row_t                 row;
      logic signed [DW-1:0] value;
      logic [31:0]          rnd;
      row = rows[r];
      program_regs(row);
      for (int i = 0; i < row.count + FLUSH; i++) begin
         if (i >= row.count)
            value = '0;   // drain tail
         else if (row.kind == IMPULSE)
            value = (i == 0) ? row.amp : '0;
         else if (row.kind == STEP)
            value = row.amp;
         else begin
            rnd   = $urandom;
            value = rnd[DW-1:0];
         end
         send_sample(value, row);
      end
      @(negedge clock);
      samp_in.valid = 1'b0;
   endtask

   task automatic set_row(input int idx, input logic prog, input logic [1:0] mode,
                          input int c0, input int c1, input int c2, input int c3,
                          input int count, input int gap_pct, input logic [1:0] kind,
                          input int amp);
      rows[idx].prog    = prog;
      rows[idx].mode    = mode;
      rows[idx].coef[0] = CW'(c0);
      rows[idx].coef[1] = CW'(c1);
      rows[idx].coef[2] = CW'(c2);
      rows[idx].coef[3] = CW'(c3);
      rows[idx].count   = count;
      rows[idx].gap_pct = gap_pct;
      rows[idx].kind    = kind;
      rows[idx].amp     = DW'(amp);
   endtask

   task automatic load_table();
      //          prog  mode  c0       c1      c2      c3      n   gap kind     amp
      set_row(0, 1'b0, 2'd0, 0,       0,      0,      0,      12, 0,  RANDOM,  0);     // reset values
      set_row(1, 1'b1, 2'd0, 24000,  -16000,  56000,  100000, 12, 0,  IMPULSE, 16384);
      set_row(2, 1'b1, 2'd1, 30000,   20000, -10000,  5000,   20, 0,  STEP,    12288);
      set_row(3, 1'b1, 2'd1, 30000,   20000, -10000,  5000,   12, 0,  IMPULSE, 16384);
      set_row(4, 1'b1, 2'd2, 9000,   -7000,   15000,  40000,  40, 0,  RANDOM,  0);
      set_row(5, 1'b1, 2'd0, 131071,  131071, 131071, 131071, 16, 0,  STEP,    32767); // clamp high
      set_row(6, 1'b1, 2'd2, 131071,  131071, 131071, 131071, 16, 0,  STEP,    32767); // clamp low
      set_row(7, 1'b1, 2'd0, 12000,  -3000,   25000, -60000,  60, 40, RANDOM,  0);
      set_row(8, 1'b1, 2'd3, -20000,  45000,  8000,   70000,  40, 25, RANDOM,  0);
   endtask

   task automatic check_reset_state();
      if (samp_out.valid !== 1'b0 || samp_out.data !== '0) begin
         value_errors++;
         $display("CHECK FAILED at %0t: out after reset expected valid 0 data 0 got %b %0d",
                  $time, samp_out.valid, samp_out.data);
      end
      if (apb_rsp.pready !== 1'b1 || apb_rsp.pslverr !== 1'b0) begin
         value_errors++;
         $display("CHECK FAILED at %0t: apb_rsp pready/pslverr expected 1/0 got %b/%b",
                  $time, apb_rsp.pready, apb_rsp.pslverr);
      end
   endtask

   // in.valid as clocked into the DUT
   always @(posedge clock)
      valid_at_edge <= samp_in.valid;

   // scoreboard at the falling edge where the registered outputs are stable
   always @(negedge clock) begin : scoreboard
      logic signed [DW-1:0] expected;
      if (arst_n) begin
         if (samp_out.valid !== valid_at_edge) begin
            value_errors++;
            $display("CHECK FAILED at %0t: out.valid expected %b got %b", $time,
                     valid_at_edge, samp_out.valid);
         end
         if (samp_out.valid === 1'b1) begin
            if (exp_q.size() == 0) begin
               other_errors++;
               $display("ERROR at %0t: output arrived with no expected value queued", $time);
            end else begin
               expected = exp_q.pop_front();
               compared++;
               if (samp_out.data !== expected) begin
                  value_errors++;
                  $display("CHECK FAILED at %0t: out.data expected %0d got %0d", $time,
                           expected, samp_out.data);
               end
            end
         end else if (samp_out.data !== held_data) begin   // must hold between samples
            value_errors++;
            $display("CHECK FAILED at %0t: out.data held value expected %0d got %0d", $time,
                     held_data, samp_out.data);
         end
         held_data = samp_out.data;
      end
   end

   always @(posedge clock) begin
      cycles++;
      if (cycles > cycle_limit) begin
         $display("ERROR: run did not finish within %0d clock cycles", cycle_limit);
         $display("Test failed");
         $finish;
      end
   end

   initial begin
      clock         = 1'b0;
      arst_n        = 1'b0;
      apb_req       = '0;
      samp_in       = '0;
      valid_at_edge = 1'b0;
      held_data     = '0;
      value_errors  = 0;
      other_errors  = 0;
      compared      = 0;
      cycles        = 0;
      void'($urandom(32'h5671d0b4));
      load_table();
      cycle_limit = 4 + MARGIN;
      for (int r = 0; r < NUM_ROWS; r++)
         cycle_limit += (rows[r].count + FLUSH) * 4 + APB_CYC;   // 4x covers capped gaps
      repeat (2) @(posedge clock);
      @(negedge clock);
      arst_n = 1'b1;
      #1;
      check_reset_state();
      for (int r = 0; r < NUM_ROWS; r++)
         run_row(r);
      repeat (3) @(negedge clock);
      if (exp_q.size() != 0) begin
         other_errors++;
         $display("ERROR: %0d expected outputs never arrived", exp_q.size());
      end
      $display("%0d outputs compared, %0d value mismatches, %0d other errors",
               compared, value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

//--- rtl/fir_top.sv
// top level of the symmetric FIR with its APB register block
// register writes reach the datapath with no extra sync, so program
// mode and coefficients only while in.valid is low
// single clock domain, asynchronous active low reset
`timescale 1ns/1ps
`include "fir_cfg.svh"

module fir_top (
   input  logic              clock,
   input  logic              arst_n,
   input  fir_pkg::apb_req_t apb_req,
   output fir_pkg::apb_rsp_t apb_rsp,
   input  fir_pkg::sample_t  in,
   output fir_pkg::sample_t  out
);

   logic signed [`FIR_HALF_TAPS-1:0][`FIR_COEF_W-1:0] coef;  // one per tap pair
   fir_pkg::slice_mode_t                              mode;

   fir_regs u_regs (
      .clock  (clock),
      .arst_n (arst_n),
      .req    (apb_req),
      .rsp    (apb_rsp),
      .coef   (coef),
      .mode   (mode)
   );

   // filter datapath, paced by in.valid
   sym_fir u_fir (
      .clock  (clock),
      .arst_n (arst_n),
      .in     (in),
      .coef   (coef),
      .mode   (mode),
      .out    (out)
   );

endmodule

//--- rtl/fir_regs.sv
// APB3 completer for the FIR mode and coefficient registers
// zero wait states, pready is always high
// writes land at the edge closing the access phase
// prdata is combinational and only nonzero on a read access phase
// unmapped addresses give pslverr, writes to them are dropped
// coefficients read back sign extended to APB_DATA_W
`timescale 1ns/1ps
`include "fir_cfg.svh"

module fir_regs (
   input  logic                                              clock,
   input  logic                                              arst_n,
   input  fir_pkg::apb_req_t                                 req,
   output fir_pkg::apb_rsp_t                                 rsp,
   output logic signed [`FIR_HALF_TAPS-1:0][`FIR_COEF_W-1:0] coef,
   output fir_pkg::slice_mode_t                              mode
);

   localparam int H      = `FIR_HALF_TAPS;
   localparam int CW     = `FIR_COEF_W;
   localparam int DATA_W = `APB_DATA_W;
   localparam int MODE_W = $bits(fir_pkg::slice_mode_t);

   logic              access;    // second cycle of a transfer
   logic              wr_en;
   logic              mode_sel;
   logic [H-1:0]      coef_sel;  // one hot
   logic              mapped;
   logic [DATA_W-1:0] rd_data;

   assign access = req.psel & req.penable;
   assign wr_en  = access & req.pwrite;

   // address decode
   always_comb begin
      mode_sel = (req.paddr == `FIR_REG_MODE);
      for (int k = 0; k < H; k++)
         coef_sel[k] = (req.paddr == `APB_ADDR_W'(`FIR_REG_COEF0 + 4 * k));
   end

   assign mapped = mode_sel | (|coef_sel);

   // register file
   always_ff @(posedge clock or negedge arst_n) begin
      if (!arst_n) begin
         mode <= '0;
         coef <= '0;   // filter outputs zero until programmed
      end else if (wr_en) begin
         if (mode_sel)
            mode <= fir_pkg::slice_mode_t'(req.pwdata[MODE_W-1:0]);
         for (int k = 0; k < H; k++) begin
            if (coef_sel[k])
               coef[k] <= req.pwdata[CW-1:0];   // upper bits ignored
         end
      end
   end

   // readback mux
   always_comb begin
      rd_data = '0;
      if (mode_sel)
         rd_data = {{(DATA_W - MODE_W){1'b0}}, mode};
      for (int k = 0; k < H; k++) begin
         if (coef_sel[k])
            rd_data = {{(DATA_W - CW){coef[k][CW-1]}}, coef[k]};
      end
   end

   assign rsp.prdata  = (access & ~req.pwrite) ? rd_data : '0;
   assign rsp.pready  = 1'b1;
   assign rsp.pslverr = access & ~mapped;

endmodule

//--- rtl/sym_fir.sv
// symmetric / antisymmetric FIR, 2*FIR_HALF_TAPS taps, transposed systolic form
// every data register advances on in.valid only, no back-pressure
// y[n] = sum_k coef[k] * (x[n-k] +/- x[n-(2H-1-k)]), negated if neg_out
// sum is shifted right by FIR_OUT_SHIFT (truncation) and saturated
// x[n] shows up on out.data FIR_SLICE_LAT + FIR_HALF_TAPS - 1 valid cycles later
// FIR_HALF_TAPS must be at least 3 for the a-side tap to exist
`timescale 1ns/1ps
`include "fir_cfg.svh"

module sym_fir (
   input  logic                                              clock,
   input  logic                                              arst_n,
   input  fir_pkg::sample_t                                  in,
   input  logic signed [`FIR_HALF_TAPS-1:0][`FIR_COEF_W-1:0] coef,
   input  fir_pkg::slice_mode_t                              mode,
   output fir_pkg::sample_t                                  out
);

   localparam int H   = `FIR_HALF_TAPS;
   localparam int DW  = `FIR_DATA_W;
   localparam int AW  = `FIR_ACC_W;
   localparam int LAT = `FIR_SLICE_LAT + H - 1;       // in to out, valid cycles
   // a feeds every slice with the same delay, the cascade supplies the k offset
   localparam int A_DLY    = LAT - `FIR_SLICE_LAT - 1; // one stage left for out reg
   // d taps are D_TOP - 2k, d path inside the slice is two stages short
   localparam int LINE_LEN = LAT - `FIR_SLICE_LAT + 2 * H;

   logic signed [DW-1:0] hist [1:LINE_LEN];  // hist[i] is x delayed i samples
   logic signed [AW-1:0] cas  [1:H];         // cas[k] = pcout of slice k
   logic signed [AW-1:0] acc_sum;            // slice 0 p
   logic signed [AW-1:0] acc_shr;
   logic                 ovf;
   logic signed [DW-1:0] sat_data;

   // sample history, shared by the forward tap and the mirrored taps
   always_ff @(posedge clock or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 1; i <= LINE_LEN; i++)
            hist[i] <= '0;
      end else if (in.valid) begin
         hist[1] <= in.data;
         for (int i = 2; i <= LINE_LEN; i++)
            hist[i] <= hist[i-1];
      end
   end

   assign cas[H] = '0;   // top of the chain starts from zero

   genvar k;
   generate
      for (k = 0; k < H; k++) begin : g_tap
         localparam int D_DLY = LINE_LEN - 2 * k;   // mirrored tap skew
         if (k == 0) begin : g_head
            mac_slice u_slice (
               .clock  (clock),
               .arst_n (arst_n),
               .ce     (in.valid),
               .mode   (mode),
               .a      (hist[A_DLY]),
               .d      (hist[D_DLY]),
               .b      (coef[k]),
               .pcin   (cas[k+1]),
               .p      (acc_sum),   // filter sum
               .pcout  ()
            );
         end else begin : g_body
            mac_slice u_slice (
               .clock  (clock),
               .arst_n (arst_n),
               .ce     (in.valid),
               .mode   (mode),
               .a      (hist[A_DLY]),
               .d      (hist[D_DLY]),
               .b      (coef[k]),
               .pcin   (cas[k+1]),
               .p      (),
               .pcout  (cas[k])     // one enabled cycle per hop toward slice 0
            );
         end
      end
   endgenerate

   // scale, then clamp anything that does not fit DW bits
   assign acc_shr  = acc_sum >>> `FIR_OUT_SHIFT;
   assign ovf      = acc_shr[AW-1:DW-1] != {(AW - DW + 1){acc_shr[AW-1]}};
   assign sat_data = !ovf ? acc_shr[DW-1:0] :
                     acc_shr[AW-1] ? {1'b1, {(DW - 1){1'b0}}}   // most negative
                                   : {1'b0, {(DW - 1){1'b1}}};  // most positive

   // out.valid follows in.valid by one clock, data holds between samples
   always_ff @(posedge clock or negedge arst_n) begin
      if (!arst_n) begin
         out <= '0;
      end else begin
         out.valid <= in.valid;
         if (in.valid)
            out.data <= sat_data;
      end
   end

endmodule

//--- rtl/mac_slice.sv
// behavioral model of one pre-add / multiply / post-add DSP slice
// p = pcin +/- b * (a +/- d), all stages share one clock enable
// a and b take FIR_SLICE_LAT enabled cycles to p, d two fewer, pcin one
// only the partial sum cascade is modelled, no a/b cascade, no c port
// mode is sampled directly, so change it only while ce is idle
`timescale 1ns/1ps
`include "fir_cfg.svh"

module mac_slice (
   input  logic                          clock,
   input  logic                          arst_n,
   input  logic                          ce,     // advances every stage
   input  fir_pkg::slice_mode_t          mode,
   input  logic signed [`FIR_DATA_W-1:0] a,
   input  logic signed [`FIR_DATA_W-1:0] d,      // joins at the pre-adder
   input  logic signed [`FIR_COEF_W-1:0] b,
   input  logic signed [`FIR_ACC_W-1:0]  pcin,   // from the slice upstream
   output logic signed [`FIR_ACC_W-1:0]  p,
   output logic signed [`FIR_ACC_W-1:0]  pcout   // to the slice downstream
);

   localparam int AD_W = `FIR_DATA_W + 1;      // pre-add grows one bit
   localparam int M_W  = AD_W + `FIR_COEF_W;   // full product width

   logic signed [`FIR_DATA_W-1:0] a1;   // input register
   logic signed [`FIR_DATA_W-1:0] a2;   // pre-add stage register
   logic signed [`FIR_COEF_W-1:0] b1;
   logic signed [`FIR_COEF_W-1:0] b2;
   logic signed [AD_W-1:0]        ad;   // pre-adder result
   logic signed [M_W-1:0]         m;    // multiply register
   logic signed [`FIR_ACC_W-1:0]  m_ext;
   logic signed [`FIR_ACC_W-1:0]  post; // post-adder result
   logic signed [`FIR_ACC_W-1:0]  p_r;  // p register

   // a and b both walk two registers before they meet d at the pre-adder
   always_ff @(posedge clock or negedge arst_n) begin
      if (!arst_n) begin
         a1 <= '0;
         a2 <= '0;
         b1 <= '0;
         b2 <= '0;
      end else if (ce) begin
         a1 <= a;
         a2 <= a1;
         b1 <= b;
         b2 <= b1;
      end
   end

   // d arrives already aligned by the caller, so no d register here
   always_comb begin
      if (mode.pre_sub)
         ad = a2 - d;   // antisymmetric pair
      else
         ad = a2 + d;   // symmetric pair
   end

   always_ff @(posedge clock or negedge arst_n) begin
      if (!arst_n)
         m <= '0;
      else if (ce)
         m <= ad * b2;   // 17x18 signed, fits M_W
   end

   // product sign extended to the cascade width
   assign m_ext = {{(`FIR_ACC_W - M_W){m[M_W-1]}}, m};

   // subtracting in every slice negates the whole sum,
   // since the last slice in the chain sees pcin = 0
   always_comb begin
      if (mode.neg_out)
         post = pcin - m_ext;
      else
         post = pcin + m_ext;
   end

   always_ff @(posedge clock or negedge arst_n) begin
      if (!arst_n)
         p_r <= '0;
      else if (ce)
         p_r <= post;
   end

   assign p     = p_r;
   assign pcout = p_r;   // same register, routed on the dedicated cascade

endmodule

//--- rtl/fir_pkg.sv
// shared types for the FIR datapath and its APB register block
// widths come from fir_cfg.svh, so the header must be on the include path
// APB here is the minimal subset without pprot or pstrb
`include "fir_cfg.svh"

package fir_pkg;

   // per-slice control, static while samples stream
   typedef struct packed {
      logic neg_out;  // post-adder subtracts the product, output sum is negated
      logic pre_sub;  // pre-adder forms a - d instead of a + d
   } slice_mode_t;

   // requester side of an APB3 transfer
   typedef struct packed {
      logic                    psel;
      logic                    penable;
      logic                    pwrite;
      logic [`APB_ADDR_W-1:0]  paddr;
      logic [`APB_DATA_W-1:0]  pwdata;
   } apb_req_t;

   // completer side
   typedef struct packed {
      logic [`APB_DATA_W-1:0]  prdata;
      logic                    pready;   // tied high in this design
      logic                    pslverr;  // unmapped address
   } apb_rsp_t;

   // valid-gated sample, no ready
   typedef struct packed {
      logic                          valid;
      logic signed [`FIR_DATA_W-1:0] data;
   } sample_t;

endpackage

//--- rtl/fir_cfg.svh
// build-time configuration of the symmetric FIR
// tap count is 2*FIR_HALF_TAPS, and FIR_HALF_TAPS must be at least 3
// FIR_SLICE_LAT matches the fixed pipeline of mac_slice and is not a knob
// APB map: mode at FIR_REG_MODE, coefficient k at FIR_REG_COEF0 + 4k
`ifndef FIR_CFG_SVH
`define FIR_CFG_SVH

// datapath widths
`define FIR_DATA_W     16   // sample width
`define FIR_COEF_W     18   // coefficient width, same as the multiplier b port
`define FIR_ACC_W      48   // cascade / partial sum width

// filter shape
`define FIR_HALF_TAPS  4    // one slice per coefficient pair
`define FIR_OUT_SHIFT  17   // acc >>> shift before saturation to FIR_DATA_W
`define FIR_SLICE_LAT  4    // a,b to p in enabled cycles

// register interface
`define APB_ADDR_W     8
`define APB_DATA_W     32
`define FIR_REG_MODE   8'h00 // bit 0 pre_sub, bit 1 neg_out
`define FIR_REG_COEF0  8'h10 // coefficients on a 4 byte stride

`endif
